// File: design/decode_pkg.sv
/* Shared decode types, instruction and postfix field positions,
   opcode constants and register alias numbers */
package decode_pkg;

// ======================================================================
// Vector types
// ======================================================================

// One 32-bit instruction, prefix or postfix word
typedef logic [31:0] word_t;
// Fetch bundle holding word 0 in the low bits, then words 1 and 2
typedef logic [95:0] bundle_t;
// Every word carries its opcode in bits 6 to 0
typedef logic [6:0]  opcode_t;
typedef logic [6:0]  aregno_t;
typedef logic [31:0] imm_t;
// Instruction length counted in words, 1 to 3
typedef logic [1:0]  ilen_t;

// ======================================================================
// Field positions
// ======================================================================

// Plain register fields are 6 bits, extended ones 7 bits
localparam int SREG_W   = 6;
localparam int AREG_W   = 7;

// Register fields of the instruction word itself
localparam int RD_POS   = 7;
localparam int RS1_POS  = 13;
localparam int RS2_POS  = 19;
// Short immediate in the top bits, sign-extended on use
localparam int SIMM_POS = 25;
localparam int SIMM_W   = 7;

// Full 7-bit register numbers carried by a REXT prefix word
localparam int XRD_POS  = 7;
localparam int XRS1_POS = 14;
localparam int XRS2_POS = 21;

// Wide immediate payload of a PFXA postfix word
localparam int PFX_POS  = 7;
localparam int PFX_W    = 25;

// ======================================================================
// Opcodes and register aliases
// ======================================================================

localparam opcode_t OP_NOP   = 7'h00;
// Register-register add, the only ALU op reading Rs2
localparam opcode_t OP_ADD   = 7'h02;
localparam opcode_t OP_ADDI  = 7'h04;
localparam opcode_t OP_ANDI  = 7'h08;
localparam opcode_t OP_ORI   = 7'h09;
localparam opcode_t OP_CMPI  = 7'h0B;
localparam opcode_t OP_SHIFT = 7'h0C;
localparam opcode_t OP_LOAD  = 7'h10;
localparam opcode_t OP_STORE = 7'h18;
localparam opcode_t OP_BCC   = 7'h20;
localparam opcode_t OP_CSR   = 7'h30;
localparam opcode_t OP_FLT   = 7'h34;
localparam opcode_t OP_PUSH  = 7'h38;
localparam opcode_t OP_POP   = 7'h39;
// Register extension prefix and wide immediate postfix
localparam opcode_t OP_REXT  = 7'h7E;
localparam opcode_t OP_PFXA  = 7'h7F;

// Register 62 reads as the instruction pointer
localparam aregno_t REG_IP   = 7'd62;

endpackage

// File: design/decode_postfix.sv
/* Prefix and postfix scanner: finds REXT and PFXA after the instruction,
   forms the immediate and the length in words */
`timescale 1ns/1ps

module decode_postfix
(
	input  decode_pkg::word_t  word1,
	input  decode_pkg::word_t  word2,
	input  decode_pkg::word_t  instr,
	output logic               has_rext,
	output decode_pkg::word_t  rext_word,
	output logic               has_imma,
	output decode_pkg::imm_t   imm,
	output decode_pkg::ilen_t  instr_len
);

// Word that may hold the PFXA, shifted back by one when a REXT is present
decode_pkg::word_t pfxa_word;
decode_pkg::imm_t  short_imm;
decode_pkg::imm_t  wide_imm;

// A REXT can only sit directly behind the instruction
assign has_rext  = word1[6:0] == decode_pkg::OP_REXT;
assign rext_word = word1;

assign pfxa_word = has_rext ? word2 : word1;
assign has_imma  = pfxa_word[6:0] == decode_pkg::OP_PFXA;

// Short field from the instruction, sign bit is bit 31
assign short_imm = {
	{(32 - decode_pkg::SIMM_W){instr[31]}},
	instr[decode_pkg::SIMM_POS +: decode_pkg::SIMM_W]
};

// The 25-bit postfix payload is sign-extended the same way
assign wide_imm = {
	{(32 - decode_pkg::PFX_W){pfxa_word[31]}},
	pfxa_word[decode_pkg::PFX_POS +: decode_pkg::PFX_W]
};

// The postfix replaces the short field completely
assign imm = has_imma ? wide_imm : short_imm;

// One word for the instruction plus one for each extra word found
assign instr_len = 2'd1 + {1'b0, has_rext} + {1'b0, has_imma};

endmodule

// File: design/decode_rs1.sv
/* First source register decoder with zero and instruction-pointer flags */
`timescale 1ns/1ps

module decode_rs1
(
	input  decode_pkg::word_t   instr,
	input  decode_pkg::word_t   rext_word,
	input  logic                has_rext,
	input  logic                has_imma,
	output decode_pkg::aregno_t rs1,
	output logic                rs1z,
	output logic                rs1ip
);

decode_pkg::opcode_t opcode;
decode_pkg::aregno_t field;
logic                uses_rs1;

assign opcode = instr[6:0];

// The REXT word carries all 7 bits, otherwise the 6-bit field is widened
assign field = has_rext ? rext_word[decode_pkg::XRS1_POS +: decode_pkg::AREG_W]
	: {1'b0, instr[decode_pkg::RS1_POS +: decode_pkg::SREG_W]};

// Opcode classes that read Rs1
always_comb
begin
	case (opcode)
	decode_pkg::OP_ADD,
	decode_pkg::OP_ADDI,
	decode_pkg::OP_ANDI,
	decode_pkg::OP_ORI,
	decode_pkg::OP_CMPI,
	decode_pkg::OP_SHIFT:
		uses_rs1 = 1'b1;
	// Memory and branch ops use Rs1 as the base or first compare operand
	decode_pkg::OP_LOAD,
	decode_pkg::OP_STORE,
	decode_pkg::OP_BCC:
		uses_rs1 = 1'b1;
	decode_pkg::OP_CSR,
	decode_pkg::OP_FLT:
		uses_rs1 = 1'b1;
	// PUSH and POP work on the stack pointer implicitly
	default:
		uses_rs1 = 1'b0;
	endcase
end

always_comb
begin
	// A wide immediate takes the place of the Rs1 operand
	if (has_imma || !uses_rs1)
		rs1 = '0;
	else
		rs1 = field;
	// Both 63 and 127 read as zero
	rs1z = &rs1[5:0];
	rs1ip = rs1 == decode_pkg::REG_IP;
end

endmodule

// File: design/decode_rs2.sv
/* Second source register decoder with zero flag */
`timescale 1ns/1ps

module decode_rs2
(
	input  decode_pkg::word_t   instr,
	input  decode_pkg::word_t   rext_word,
	input  logic                has_rext,
	output decode_pkg::aregno_t rs2,
	output logic                rs2z
);

decode_pkg::opcode_t opcode;
decode_pkg::aregno_t field;
logic                uses_rs2;

assign opcode = instr[6:0];

// Extended field from the prefix, or the plain field zero-extended
assign field = has_rext ? rext_word[decode_pkg::XRS2_POS +: decode_pkg::AREG_W]
	: {1'b0, instr[decode_pkg::RS2_POS +: decode_pkg::SREG_W]};

// Only register-register ops, stores, branches and FP read Rs2
always_comb
begin
	case (opcode)
	decode_pkg::OP_ADD,
	decode_pkg::OP_FLT:
		uses_rs2 = 1'b1;
	// Store data register
	decode_pkg::OP_STORE:
		uses_rs2 = 1'b1;
	// Second compare operand
	decode_pkg::OP_BCC:
		uses_rs2 = 1'b1;
	default:
		uses_rs2 = 1'b0;
	endcase
end

always_comb
begin
	rs2 = uses_rs2 ? field : '0;
	// Low six bits all set names the zero register
	rs2z = &rs2[5:0];
end

endmodule

// File: design/decode_rd.sv
/* Destination register decoder */
`timescale 1ns/1ps

module decode_rd
(
	input  decode_pkg::word_t   instr,
	input  decode_pkg::word_t   rext_word,
	input  logic                has_rext,
	output decode_pkg::aregno_t rd
);

decode_pkg::opcode_t opcode;
decode_pkg::aregno_t field;
logic                writes_rd;

assign opcode = instr[6:0];

// Same extension rule as the source fields
assign field = has_rext ? rext_word[decode_pkg::XRD_POS +: decode_pkg::AREG_W]
	: {1'b0, instr[decode_pkg::RD_POS +: decode_pkg::SREG_W]};

// Opcode classes that write a register
always_comb
begin
	case (opcode)
	decode_pkg::OP_ADD,
	decode_pkg::OP_ADDI,
	decode_pkg::OP_ANDI,
	decode_pkg::OP_ORI,
	decode_pkg::OP_SHIFT:
		writes_rd = 1'b1;
	// Compares leave their result in a register too
	decode_pkg::OP_CMPI:
		writes_rd = 1'b1;
	decode_pkg::OP_LOAD,
	decode_pkg::OP_POP:
		writes_rd = 1'b1;
	decode_pkg::OP_CSR,
	decode_pkg::OP_FLT:
		writes_rd = 1'b1;
	// Stores, branches and PUSH have no register result
	default:
		writes_rd = 1'b0;
	endcase
end

// Register 0 stands for no destination
always_comb
begin
	if (writes_rd)
		rd = field;
	else
		rd = '0;
end

endmodule

// File: design/decode_stage.sv
/* Registered decode stage: splits the fetch bundle, runs the prefix scanner
   and register decoders, holds results under stall */
`timescale 1ns/1ps

module decode_stage
(
	input  logic                clk,
	input  logic                rst,
	input  logic                in_valid,
	input  decode_pkg::bundle_t bundle,
	input  logic                stall,
	output logic                in_ready,
	output logic                out_valid,
	output decode_pkg::aregno_t rd,
	output decode_pkg::aregno_t rs1,
	output decode_pkg::aregno_t rs2,
	output logic                rs1z,
	output logic                rs1ip,
	output logic                rs2z,
	output logic                has_imma,
	output decode_pkg::imm_t    imm,
	output decode_pkg::ilen_t   instr_len
);

// ======================================================================
// Combinational decode
// ======================================================================

decode_pkg::word_t   word0;
decode_pkg::word_t   word1;
decode_pkg::word_t   word2;
decode_pkg::word_t   rext_word;
logic                has_rext;
logic                dec_has_imma;
decode_pkg::imm_t    dec_imm;
decode_pkg::ilen_t   dec_len;
decode_pkg::aregno_t dec_rd;
decode_pkg::aregno_t dec_rs1;
decode_pkg::aregno_t dec_rs2;
logic                dec_rs1z;
logic                dec_rs1ip;
logic                dec_rs2z;
logic                accept;

// Word 0 is the instruction, the next two may be prefix or postfix
assign word0 = bundle[31:0];
assign word1 = bundle[63:32];
assign word2 = bundle[95:64];

decode_postfix u_postfix
(
	.word1     (word1),
	.word2     (word2),
	.instr     (word0),
	.has_rext  (has_rext),
	.rext_word (rext_word),
	.has_imma  (dec_has_imma),
	.imm       (dec_imm),
	.instr_len (dec_len)
);

decode_rs1 u_rs1
(
	.instr     (word0),
	.rext_word (rext_word),
	.has_rext  (has_rext),
	.has_imma  (dec_has_imma),
	.rs1       (dec_rs1),
	.rs1z      (dec_rs1z),
	.rs1ip     (dec_rs1ip)
);

decode_rs2 u_rs2
(
	.instr     (word0),
	.rext_word (rext_word),
	.has_rext  (has_rext),
	.rs2       (dec_rs2),
	.rs2z      (dec_rs2z)
);

decode_rd u_rd
(
	.instr     (word0),
	.rext_word (rext_word),
	.has_rext  (has_rext),
	.rd        (dec_rd)
);

// ======================================================================
// Output register
// ======================================================================

// Only one item is in flight, so the stage is ready whenever not stalled
assign in_ready = ~stall;
assign accept = in_valid & in_ready;

always_ff @(posedge clk)
begin
	if (rst)
	begin
		out_valid <= 1'b0;
		rd <= '0;
		rs1 <= '0;
		rs2 <= '0;
		rs1z <= 1'b0;
		rs1ip <= 1'b0;
		rs2z <= 1'b0;
		has_imma <= 1'b0;
		imm <= '0;
		instr_len <= '0;
	end
	// Everything freezes while downstream stalls
	else if (!stall)
	begin
		out_valid <= accept;
		// Without a new bundle the old fields stay, only valid drops
		if (accept)
		begin
			rd <= dec_rd;
			rs1 <= dec_rs1;
			rs2 <= dec_rs2;
			rs1z <= dec_rs1z;
			rs1ip <= dec_rs1ip;
			rs2z <= dec_rs2z;
			has_imma <= dec_has_imma;
			imm <= dec_imm;
			instr_len <= dec_len;
		end
	end
end

// Nothing may appear valid in the first cycle out of reset
assert property (@(posedge clk) rst |=> !out_valid);

// A stall seen at one edge keeps the whole output bundle for the next cycle
assert property (@(posedge clk) disable iff (rst)
	stall |=> $stable({out_valid, rd, rs1, rs2, rs1z, rs1ip, rs2z,
		has_imma, imm, instr_len}));

endmodule

// File: tb/tb_decode_tasks.svh
/* Reference model, value check, bundle builders and the directed and
   random tests of the decode stage testbench */
`ifndef TB_DECODE_TASKS_SVH
`define TB_DECODE_TASKS_SVH

// ======================================================================
// Model and checks
// ======================================================================

task automatic compare(input string name, input logic [31:0] got, input logic [31:0] want);
	if (got !== want)
	begin
		$display("mismatch %s: got %h expected %h", name, got, want);
		$display("RESULT: FAIL");
		$fatal(1, "stopped at the first mismatch");
	end
endtask

// A used field comes from the REXT word if present, else the 6-bit field widened
function automatic decode_pkg::aregno_t reg_field(input logic used, input logic rext,
	input logic [6:0] wide, input logic [5:0] narrow);
	if (!used)
		return 7'd0;
	else if (rext)
		return wide;
	else
		return {1'b0, narrow};
endfunction

task automatic predict(input decode_pkg::bundle_t b);
	decode_pkg::word_t w0;
	decode_pkg::word_t w1;
	decode_pkg::word_t pw;
	decode_pkg::opcode_t op;
	logic rext;
	w0 = b[31:0];
	w1 = b[63:32];
	op = w0[6:0];
	rext = w1[6:0] == decode_pkg::OP_REXT;
	// The PFXA word sits behind the REXT when there is one
	pw = rext ? b[95:64] : w1;
	exp_imma = pw[6:0] == decode_pkg::OP_PFXA;
	exp_len = 2'd1 + 2'(rext) + 2'(exp_imma);
	exp_imm = exp_imma ? {{7{pw[31]}}, pw[31:7]} : {{25{w0[31]}}, w0[31:25]};
	exp_rs1 = reg_field(!exp_imma && (op inside {decode_pkg::OP_ADD, decode_pkg::OP_ADDI,
		decode_pkg::OP_ANDI, decode_pkg::OP_ORI, decode_pkg::OP_CMPI, decode_pkg::OP_SHIFT,
		decode_pkg::OP_LOAD, decode_pkg::OP_STORE, decode_pkg::OP_BCC, decode_pkg::OP_CSR,
		decode_pkg::OP_FLT}), rext, w1[20:14], w0[18:13]);
	exp_rs2 = reg_field(op inside {decode_pkg::OP_ADD, decode_pkg::OP_STORE,
		decode_pkg::OP_BCC, decode_pkg::OP_FLT}, rext, w1[27:21], w0[24:19]);
	exp_rd = reg_field(op inside {decode_pkg::OP_ADD, decode_pkg::OP_ADDI, decode_pkg::OP_ANDI,
		decode_pkg::OP_ORI, decode_pkg::OP_CMPI, decode_pkg::OP_SHIFT, decode_pkg::OP_LOAD,
		decode_pkg::OP_CSR, decode_pkg::OP_FLT, decode_pkg::OP_POP}, rext, w1[13:7], w0[12:7]);
	// Low six bits all ones name the zero register, and 62 is the IP alias
	exp_rs1z = &exp_rs1[5:0];
	exp_rs1ip = exp_rs1 == 7'd62;
	exp_rs2z = &exp_rs2[5:0];
endtask

task automatic expect_outputs();
	compare("rd", 32'(rd), 32'(exp_rd));
	compare("rs1", 32'(rs1), 32'(exp_rs1));
	compare("rs2", 32'(rs2), 32'(exp_rs2));
	compare("rs1z", 32'(rs1z), 32'(exp_rs1z));
	compare("rs1ip", 32'(rs1ip), 32'(exp_rs1ip));
	compare("rs2z", 32'(rs2z), 32'(exp_rs2z));
	compare("has_imma", 32'(has_imma), 32'(exp_imma));
	compare("imm", imm, exp_imm);
	compare("instr_len", 32'(instr_len), 32'(exp_len));
endtask

// Offers one bundle, then waits for out_valid and checks every output
task automatic send_bundle(input decode_pkg::bundle_t b);
	int waited;
	waited = 0;
	@(negedge clk);
	compare("in_ready", 32'(in_ready), 32'd1);
	bundle = b;
	in_valid = 1'b1;
	predict(b);
	@(negedge clk);
	in_valid = 1'b0;
	while (!out_valid)
	begin
		@(negedge clk);
		waited++;
	end
	// The result belongs right behind the accepting edge
	compare("latency", 32'(waited), 32'd0);
	expect_outputs();
endtask

// ======================================================================
// Bundle builders
// ======================================================================

function automatic decode_pkg::word_t instr_word(input decode_pkg::opcode_t op,
	input logic [5:0] rd6, input logic [5:0] rs1_6, input logic [5:0] rs2_6,
	input logic [6:0] simm);
	return {simm, rs2_6, rs1_6, rd6, op};
endfunction

function automatic decode_pkg::word_t rext_prefix(input logic [6:0] rd7,
	input logic [6:0] rs1_7, input logic [6:0] rs2_7);
	return {4'h0, rs2_7, rs1_7, rd7, decode_pkg::OP_REXT};
endfunction

function automatic decode_pkg::word_t pfxa_postfix(input logic [24:0] payload);
	return {payload, decode_pkg::OP_PFXA};
endfunction

// ======================================================================
// Tests
// ======================================================================

task automatic reset_state();
	// Out of reset nothing is valid and the output registers are clear
	compare("out_valid", 32'(out_valid), 32'd0);
	compare("rd rs1 rs2", 32'({rd, rs1, rs2}), 32'd0);
	compare("imm", imm, 32'd0);
	compare("flags and instr_len", 32'({rs1z, rs1ip, rs2z, has_imma, instr_len}), 32'd0);
endtask

// Each opcode once on its own and once behind a REXT prefix
task automatic opcode_classes();
	decode_pkg::word_t w0;
	for (int i = 0; i < 14; i++)
	begin
		w0 = instr_word(plain_ops[4'(i)], 6'(i + 1), 6'(i + 20), 6'(i + 40), 7'(i * 9));
		send_bundle({32'h0, 32'h0, w0});
		send_bundle({32'h0, rext_prefix(7'(i + 64), 7'(i + 80), 7'(i + 100)), w0});
	end
endtask

task automatic pfxa_forms();
	send_bundle({32'h0, pfxa_postfix(25'h1234567),
		instr_word(decode_pkg::OP_ADDI, 6'd7, 6'd8, 6'd9, 7'h05)});
	send_bundle({32'h0, pfxa_postfix(25'h0ABCDEF),
		instr_word(decode_pkg::OP_STORE, 6'd1, 6'd2, 6'd3, 7'h7F)});
	send_bundle({pfxa_postfix(25'h1FFFF00), rext_prefix(7'd90, 7'd91, 7'd92),
		instr_word(decode_pkg::OP_LOAD, 6'd4, 6'd5, 6'd6, 7'h00)});
	send_bundle({pfxa_postfix(25'h0000123), rext_prefix(7'd100, 7'd120, 7'd127),
		instr_word(decode_pkg::OP_ADD, 6'd10, 6'd11, 6'd12, 7'h33)});
	// Without a REXT a PFXA in word 2 is not part of this instruction
	send_bundle({pfxa_postfix(25'h0000456), 32'h0,
		instr_word(decode_pkg::OP_ORI, 6'd13, 6'd14, 6'd15, 7'h3C)});
endtask

task automatic register_aliases();
	send_bundle({64'h0, instr_word(decode_pkg::OP_ADD, 6'd1, 6'd62, 6'd63, 7'h00)});
	send_bundle({64'h0, instr_word(decode_pkg::OP_STORE, 6'd1, 6'd63, 6'd62, 7'h00)});
	send_bundle({32'h0, rext_prefix(7'd5, 7'd127, 7'd127),
		instr_word(decode_pkg::OP_FLT, 6'd0, 6'd0, 6'd0, 7'h00)});
	send_bundle({32'h0, rext_prefix(7'd5, 7'd62, 7'd63),
		instr_word(decode_pkg::OP_CMPI, 6'd0, 6'd0, 6'd0, 7'h00)});
	// 126 shares its low bits with 62 but is neither alias
	send_bundle({32'h0, rext_prefix(7'd5, 7'd126, 7'd62),
		instr_word(decode_pkg::OP_BCC, 6'd0, 6'd0, 6'd0, 7'h00)});
	// Fields the opcode ignores never raise a flag
	send_bundle({64'h0, instr_word(decode_pkg::OP_PUSH, 6'd63, 6'd62, 6'd63, 7'h00)});
endtask

task automatic stall_hold();
	decode_pkg::bundle_t held;
	held = {64'h0, instr_word(decode_pkg::OP_ADD, 6'd3, 6'd4, 6'd5, 7'h11)};
	send_bundle({32'h0, rext_prefix(7'd70, 7'd80, 7'd90),
		instr_word(decode_pkg::OP_STORE, 6'd9, 6'd8, 6'd7, 7'h22)});
	// Downstream stalls while the next bundle waits at the input
	stall = 1'b1;
	bundle = held;
	in_valid = 1'b1;
	repeat (3)
	begin
		@(negedge clk);
		compare("in_ready", 32'(in_ready), 32'd0);
		compare("out_valid", 32'(out_valid), 32'd1);
		expect_outputs();
	end
	stall = 1'b0;
	predict(held);
	@(negedge clk);
	in_valid = 1'b0;
	compare("out_valid", 32'(out_valid), 32'd1);
	expect_outputs();
	// No new input and no stall, so valid drops after one more edge
	@(negedge clk);
	compare("out_valid", 32'(out_valid), 32'd0);
endtask

function automatic decode_pkg::word_t random_word(input decode_pkg::opcode_t op);
	return {25'(lfsr_bits(25)), op};
endfunction

task automatic random_bundles(input int count);
	decode_pkg::word_t w0;
	decode_pkg::word_t w1;
	decode_pkg::word_t w2;
	logic with_rext;
	logic with_pfxa;
	for (int n = 0; n < count; n++)
	begin
		with_rext = 1'(lfsr_bits(1));
		with_pfxa = 1'(lfsr_bits(1));
		w0 = random_word(random_opcode());
		w1 = random_word(random_opcode());
		w2 = random_word(random_opcode());
		// Random payload bits stay, only the opcode marks a prefix or postfix
		if (with_rext)
			w1[6:0] = decode_pkg::OP_REXT;
		else if (with_pfxa)
			w1[6:0] = decode_pkg::OP_PFXA;
		if (with_rext && with_pfxa)
			w2[6:0] = decode_pkg::OP_PFXA;
		send_bundle({w2, w1, w0});
	end
endtask

`endif

// File: tb/tb_decode.sv
/* Testbench top for the decode stage: clock, reset, DUT, cycle limit,
   LFSR random source and the test sequence */
`timescale 1ns/1ps

module tb_decode;

// The tests take about 550 cycles, so this limit leaves wide margin
localparam int MAX_CYCLES = 2000;
localparam int RANDOM_COUNT = 200;

logic clk;
logic rst;
logic in_valid;
logic stall;
decode_pkg::bundle_t bundle;
logic in_ready, out_valid;
logic rs1z, rs1ip, rs2z, has_imma;
decode_pkg::aregno_t rd, rs1, rs2;
decode_pkg::imm_t imm;
decode_pkg::ilen_t instr_len;

// Reference model results for the bundle in flight
decode_pkg::aregno_t exp_rd, exp_rs1, exp_rs2;
logic exp_rs1z, exp_rs1ip, exp_rs2z, exp_imma;
decode_pkg::imm_t exp_imm;
decode_pkg::ilen_t exp_len;

int cycles = 0;
logic [15:0] lfsr;
// Every opcode that is neither a prefix nor a postfix
decode_pkg::opcode_t plain_ops [14];

decode_stage DUT (.*);

// Galois LFSR with taps 16, 14, 13, 11, stepped once for every bit taken
function automatic logic [31:0] lfsr_bits(input int count);
	logic [31:0] result;
	result = '0;
	for (int i = 0; i < count; i++)
	begin
		result = {result[30:0], lfsr[0]};
		lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
	end
	return result;
endfunction

function automatic decode_pkg::opcode_t random_opcode();
	return plain_ops[4'(lfsr_bits(4) % 14)];
endfunction

`include "tb_decode_tasks.svh"

initial
begin
	clk = 1'b0;
	forever
		#2 clk = ~clk;
end

always @(posedge clk)
begin
	cycles <= cycles + 1;
	if (cycles >= MAX_CYCLES)
	begin
		$display("timeout: decode tests still running after %0d cycles", MAX_CYCLES);
		$display("RESULT: FAIL");
		$fatal(1, "run aborted by the cycle limit");
	end
end

initial
begin
	rst = 1'b1;
	in_valid = 1'b0;
	stall = 1'b0;
	bundle = '0;
	lfsr = 16'd58859;
	plain_ops = '{decode_pkg::OP_NOP, decode_pkg::OP_ADD, decode_pkg::OP_ADDI,
		decode_pkg::OP_ANDI, decode_pkg::OP_ORI, decode_pkg::OP_CMPI, decode_pkg::OP_SHIFT,
		decode_pkg::OP_LOAD, decode_pkg::OP_STORE, decode_pkg::OP_BCC, decode_pkg::OP_CSR,
		decode_pkg::OP_FLT, decode_pkg::OP_PUSH, decode_pkg::OP_POP};
	repeat (4)
		@(posedge clk);
	@(negedge clk);
	rst = 1'b0;
	reset_state();
	opcode_classes();
	pfxa_forms();
	register_aliases();
	stall_hold();
	random_bundles(RANDOM_COUNT);
	$display("RESULT: PASS");
	$finish;
end

endmodule

// File: sources.f
+incdir+tb
design/decode_pkg.sv
design/decode_postfix.sv
design/decode_rs1.sv
design/decode_rs2.sv
design/decode_rd.sv
design/decode_stage.sv
tb/tb_decode.sv

// File: Makefile
# Verilator build and run of the decode stage testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f sources.f --top-module tb_decode -Mdir obj_dir
	@out="$$(./obj_dir/Vtb_decode)"; echo "$$out"; echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf obj_dir
